/* design/serv_pkg.sv */
package serv_pkg;

   localparam int XLEN = 32;

   typedef logic [XLEN-1:0] word_t;
   typedef logic [4:0]      reg_addr_t;
   typedef logic [4:0]      bit_cnt_t;

   // Major opcodes
   localparam logic [6:0] OPC_OP     = 7'b0110011;
   localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
   localparam logic [6:0] OPC_LUI    = 7'b0110111;
   localparam logic [6:0] OPC_AUIPC  = 7'b0010111;

   localparam logic [2:0] F3_ADD_SUB = 3'b000;
   localparam logic [2:0] F3_XOR     = 3'b100;
   localparam logic [2:0] F3_OR      = 3'b110;
   localparam logic [2:0] F3_AND     = 3'b111;

   typedef enum logic [2:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_OR,
      ALU_XOR
   } alu_op_t;

   typedef enum logic [1:0] {
      ST_FETCH,
      ST_RF_REQ,
      ST_RF_WAIT,
      ST_EXEC
   } state_t;

   typedef struct packed {
      alu_op_t alu_op;
      logic    op_b_imm;
      logic    utype;
      logic    pc_rel;
      logic    rd_from_ctrl;
      logic    rd_we;
   } ctrl_t;

endpackage

/* design/serv_counter.sv */
`timescale 1ns/1ps
`default_nettype none

module serv_counter import serv_pkg::*; (
   input  logic clk,
   input  logic i_reset,
   input  logic i_cnt_en,
   output logic o_cnt0,
   output logic o_cnt_done
);

   bit_cnt_t cnt;

   // Wraps from 31 back to 0 on its own
   always_ff @(posedge clk) begin
      if (i_reset) begin
         cnt <= '0;
      end else if (i_cnt_en) begin
         cnt <= cnt + bit_cnt_t'(1);
      end
   end

   assign o_cnt0     = (cnt == '0);
   assign o_cnt_done = (cnt == '1);

endmodule
`default_nettype wire

/* design/serv_state.sv */
`timescale 1ns/1ps
`default_nettype none

module serv_state import serv_pkg::*; (
   input  logic clk,
   input  logic i_reset,
   input  logic i_ibus_ack,
   input  logic i_rf_ready,
   input  logic i_cnt_done,
   output logic o_ibus_cyc,
   output logic o_rf_rreq,
   output logic o_cnt_en
);

   state_t state;
   state_t state_nxt;

   always_comb begin
      state_nxt = state;
      case (state)
         ST_FETCH: begin
            if (o_ibus_cyc && i_ibus_ack) begin
               state_nxt = ST_RF_REQ;
            end
         end
         ST_RF_REQ: begin
            state_nxt = ST_RF_WAIT;
         end
         ST_RF_WAIT: begin
            if (i_rf_ready) begin
               state_nxt = ST_EXEC;
            end
         end
         ST_EXEC: begin
            // Count 31 closes the instruction
            if (i_cnt_done) begin
               state_nxt = ST_FETCH;
            end
         end
         default: begin
            state_nxt = ST_FETCH;
         end
      endcase
   end

   // Strobes are registered from the next state so they are low in reset
   always_ff @(posedge clk) begin
      if (i_reset) begin
         state      <= ST_FETCH;
         o_ibus_cyc <= 1'b0;
         o_rf_rreq  <= 1'b0;
         o_cnt_en   <= 1'b0;
      end else begin
         state      <= state_nxt;
         o_ibus_cyc <= (state_nxt == ST_FETCH);
         o_rf_rreq  <= (state_nxt == ST_RF_REQ);
         o_cnt_en   <= (state_nxt == ST_EXEC);
      end
   end

endmodule
`default_nettype wire

/* design/serv_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module serv_decode import serv_pkg::*; (
   input  logic  clk,
   input  logic  i_ibus_ack,
   input  word_t i_ibus_rdt,
   output ctrl_t o_ctrl
);

   logic [6:0] opcode;
   logic [2:0] funct3;
   logic       funct7_b5;
   reg_addr_t  rd;
   logic       legal;
   ctrl_t      ctrl_d;

   assign opcode    = i_ibus_rdt[6:0];
   assign funct3    = i_ibus_rdt[14:12];
   assign funct7_b5 = i_ibus_rdt[30];
   assign rd        = i_ibus_rdt[11:7];

   always_comb begin
      legal               = 1'b1;
      ctrl_d              = '0;
      ctrl_d.alu_op       = ALU_ADD;
      ctrl_d.op_b_imm     = (opcode != OPC_OP);
      ctrl_d.utype        = (opcode == OPC_LUI) || (opcode == OPC_AUIPC);
      ctrl_d.pc_rel       = (opcode == OPC_AUIPC);
      ctrl_d.rd_from_ctrl = ctrl_d.utype;

      if ((opcode == OPC_OP) || (opcode == OPC_OP_IMM)) begin
         case (funct3)
            // Bit 30 is part of the immediate for OP-IMM, so SUB only on OP
            F3_ADD_SUB: ctrl_d.alu_op = (opcode == OPC_OP && funct7_b5) ? ALU_SUB : ALU_ADD;
            F3_XOR:     ctrl_d.alu_op = ALU_XOR;
            F3_OR:      ctrl_d.alu_op = ALU_OR;
            F3_AND:     ctrl_d.alu_op = ALU_AND;
            default:    legal = 1'b0;
         endcase
         if (opcode == OPC_OP && funct7_b5 && funct3 != F3_ADD_SUB) begin
            legal = 1'b0;
         end
      end else if (!ctrl_d.utype) begin
         legal = 1'b0;
      end

      // Writes to x0 are dropped
      ctrl_d.rd_we = legal && (rd != '0);
   end

   always_ff @(posedge clk) begin
      if (i_ibus_ack) begin
         o_ctrl <= ctrl_d;
      end
   end

endmodule
`default_nettype wire

/* design/serv_immdec.sv */
`timescale 1ns/1ps
`default_nettype none

module serv_immdec import serv_pkg::*; (
   input  logic      clk,
   input  logic      i_ibus_ack,
   input  word_t     i_ibus_rdt,
   input  logic      i_utype,
   input  logic      i_cnt_en,
   output reg_addr_t o_rs1_addr,
   output reg_addr_t o_rs2_addr,
   output reg_addr_t o_rd_addr,
   output logic      o_imm
);

   logic [19:0] imm_field;
   word_t       imm_word;
   word_t       imm_q;

   always_ff @(posedge clk) begin
      if (i_ibus_ack) begin
         o_rs1_addr <= i_ibus_rdt[19:15];
         o_rs2_addr <= i_ibus_rdt[24:20];
         o_rd_addr  <= i_ibus_rdt[11:7];
         imm_field  <= i_ibus_rdt[31:12];
      end
   end

   // utype is only valid after the ack edge, so format from the held field
   assign imm_word = i_utype ? {imm_field, 12'b0}
                             : {{20{imm_field[19]}}, imm_field[19:8]};

   // Reloads while idle, shifts LSB first during the count
   always_ff @(posedge clk) begin
      if (i_cnt_en) begin
         imm_q <= {imm_q[XLEN-1], imm_q[XLEN-1:1]};
      end else begin
         imm_q <= imm_word;
      end
   end

   assign o_imm = imm_q[0];

endmodule
`default_nettype wire

/* design/serv_alu.sv */
`timescale 1ns/1ps
`default_nettype none

module serv_alu import serv_pkg::*; (
   input  logic  clk,
   input  logic  i_cnt_en,
   input  logic  i_cnt0,
   input  ctrl_t i_ctrl,
   input  logic  i_rs1,
   input  logic  i_rs2,
   input  logic  i_imm,
   output logic  o_rd
);

   logic op_b;
   logic sub;
   logic b_add;
   logic carry_in;
   logic carry_q;
   logic sum;

   assign op_b = i_ctrl.op_b_imm ? i_imm : i_rs2;
   assign sub  = (i_ctrl.alu_op == ALU_SUB);

   // Two's complement subtract, B inverted and +1 at bit 0
   assign b_add    = op_b ^ sub;
   assign carry_in = i_cnt0 ? sub : carry_q;
   assign sum      = i_rs1 ^ b_add ^ carry_in;

   always_ff @(posedge clk) begin
      if (i_cnt_en) begin
         carry_q <= (i_rs1 & b_add) | (carry_in & (i_rs1 ^ b_add));
      end
   end

   always_comb begin
      case (i_ctrl.alu_op)
         ALU_AND: o_rd = i_rs1 & op_b;
         ALU_OR:  o_rd = i_rs1 | op_b;
         ALU_XOR: o_rd = i_rs1 ^ op_b;
         default: o_rd = sum;
      endcase
   end

endmodule
`default_nettype wire

/* design/serv_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module serv_ctrl import serv_pkg::*; #(
   parameter word_t RESET_PC = '0
) (
   input  logic  clk,
   input  logic  i_reset,
   input  logic  i_cnt_en,
   input  logic  i_cnt0,
   input  ctrl_t i_ctrl,
   input  logic  i_imm,
   input  logic  i_alu_rd,
   output word_t o_ibus_adr,
   output logic  o_rd
);

   word_t      pc;
   logic [1:0] cnt0_dly;
   logic       plus4;
   logic       pc_cin;
   logic       pc_c_q;
   logic       pc_sum;
   logic       aui_cin;
   logic       aui_c_q;
   logic       aui_sum;
   logic       upper_rd;

   // Delayed cnt0 marks bit 2, where the +4 goes in
   always_ff @(posedge clk) begin
      if (i_reset) begin
         cnt0_dly <= '0;
      end else if (i_cnt_en) begin
         cnt0_dly <= {cnt0_dly[0], i_cnt0};
      end
   end
   assign plus4 = cnt0_dly[1];

   assign pc_cin = i_cnt0 ? 1'b0 : pc_c_q;
   assign pc_sum = pc[0] ^ plus4 ^ pc_cin;

   // PC rotates LSB out, incremented bit back in at the top
   always_ff @(posedge clk) begin
      if (i_reset) begin
         pc <= RESET_PC;
      end else if (i_cnt_en) begin
         pc <= {pc_sum, pc[XLEN-1:1]};
      end
   end

   assign aui_cin = i_cnt0 ? 1'b0 : aui_c_q;
   assign aui_sum = pc[0] ^ i_imm ^ aui_cin;

   always_ff @(posedge clk) begin
      if (i_cnt_en) begin
         pc_c_q  <= (pc[0] & plus4) | (pc_cin & (pc[0] ^ plus4));
         aui_c_q <= (pc[0] & i_imm) | (aui_cin & (pc[0] ^ i_imm));
      end
   end

   // LUI passes the immediate, AUIPC adds the old PC
   assign upper_rd = i_ctrl.pc_rel ? aui_sum : i_imm;

   assign o_rd       = i_ctrl.rd_from_ctrl ? upper_rd : i_alu_rd;
   assign o_ibus_adr = pc;

endmodule
`default_nettype wire

/* design/serv_top.sv */
`timescale 1ns/1ps
`default_nettype none

module serv_top import serv_pkg::*; #(
   parameter word_t RESET_PC = '0
) (
   input  logic      clk,
   input  logic      i_reset,
   // Instruction bus
   output word_t     o_ibus_adr,
   output logic      o_ibus_cyc,
   input  word_t     i_ibus_rdt,
   input  logic      i_ibus_ack,
   // Register file
   output logic      o_rf_rreq,
   output reg_addr_t o_rreg0,
   output reg_addr_t o_rreg1,
   input  logic      i_rf_ready,
   input  logic      i_rdata0,
   input  logic      i_rdata1,
   output reg_addr_t o_wreg0,
   output logic      o_wen0,
   output logic      o_wdata0
);

   ctrl_t ctrl;
   logic  cnt_en;
   logic  cnt0;
   logic  cnt_done;
   logic  imm;
   logic  alu_rd;

   serv_state state (
      .clk        (clk),
      .i_reset    (i_reset),
      .i_ibus_ack (i_ibus_ack),
      .i_rf_ready (i_rf_ready),
      .i_cnt_done (cnt_done),
      .o_ibus_cyc (o_ibus_cyc),
      .o_rf_rreq  (o_rf_rreq),
      .o_cnt_en   (cnt_en)
   );

   serv_counter counter (
      .clk        (clk),
      .i_reset    (i_reset),
      .i_cnt_en   (cnt_en),
      .o_cnt0     (cnt0),
      .o_cnt_done (cnt_done)
   );

   serv_decode decode (
      .clk        (clk),
      .i_ibus_ack (i_ibus_ack),
      .i_ibus_rdt (i_ibus_rdt),
      .o_ctrl     (ctrl)
   );

   serv_immdec immdec (
      .clk        (clk),
      .i_ibus_ack (i_ibus_ack),
      .i_ibus_rdt (i_ibus_rdt),
      .i_utype    (ctrl.utype),
      .i_cnt_en   (cnt_en),
      .o_rs1_addr (o_rreg0),
      .o_rs2_addr (o_rreg1),
      .o_rd_addr  (o_wreg0),
      .o_imm      (imm)
   );

   serv_alu alu (
      .clk      (clk),
      .i_cnt_en (cnt_en),
      .i_cnt0   (cnt0),
      .i_ctrl   (ctrl),
      .i_rs1    (i_rdata0),
      .i_rs2    (i_rdata1),
      .i_imm    (imm),
      .o_rd     (alu_rd)
   );

   serv_ctrl #(
      .RESET_PC (RESET_PC)
   ) ctrl_i (
      .clk        (clk),
      .i_reset    (i_reset),
      .i_cnt_en   (cnt_en),
      .i_cnt0     (cnt0),
      .i_ctrl     (ctrl),
      .i_imm      (imm),
      .i_alu_rd   (alu_rd),
      .o_ibus_adr (o_ibus_adr),
      .o_rd       (o_wdata0)
   );

   // Write strobe follows the execute window
   assign o_wen0 = cnt_en & ctrl.rd_we;

endmodule
`default_nettype wire

/* dv/serv_tb_vectors.svh */
`ifndef SERV_TB_VECTORS_SVH
`define SERV_TB_VECTORS_SVH

// Columns: instruction, rs1 value, rs2 value, expected rd value, expected write enable
// AUIPC rows hold the absolute result for their fetch address
localparam int NUM_ROWS = 24;

vec_t vectors [NUM_ROWS];

task automatic load_vectors();
   // Register-register ADD, SUB, AND, OR, XOR
   vectors[0]  = {32'h002081b3, 32'h12345678, 32'h11111111, 32'h23456789, 1'b1};
   vectors[1]  = {32'h007302b3, 32'hffffffff, 32'h00000002, 32'h00000001, 1'b1};
   vectors[2]  = {32'h40208233, 32'h00000005, 32'h00000007, 32'hfffffffe, 1'b1};
   vectors[3]  = {32'h40c58533, 32'h80000000, 32'h00000001, 32'h7fffffff, 1'b1};
   vectors[4]  = {32'h00a4f433, 32'hf0f0f0f0, 32'hff00ff00, 32'hf000f000, 1'b1};
   vectors[5]  = {32'h00f766b3, 32'h0f0f0000, 32'h00f000f0, 32'h0fff00f0, 1'b1};
   vectors[6]  = {32'h01df4fb3, 32'haaaa5555, 32'h5555ffff, 32'hffffaaaa, 1'b1};
   // Immediate forms, rs2 carries junk
   vectors[7]  = {32'h06410093, 32'h00000010, 32'hdeadbeef, 32'h00000074, 1'b1};
   vectors[8]  = {32'hfff40393, 32'h00000000, 32'h12345678, 32'hffffffff, 1'b1};
   vectors[9]  = {32'h80048493, 32'h00001000, 32'hcafef00d, 32'h00000800, 1'b1};
   vectors[10] = {32'hff06f613, 32'h1234567f, 32'h0000ffff, 32'h12345670, 1'b1};
   vectors[11] = {32'h7ff7e713, 32'h80000000, 32'hffffffff, 32'h800007ff, 1'b1};
   vectors[12] = {32'hfff8c813, 32'h0f0f1234, 32'h00000000, 32'hf0f0edcb, 1'b1};
   vectors[13] = {32'h1239c913, 32'h00000f0f, 32'h5a5a5a5a, 32'h00000e2c, 1'b1};
   // LUI and AUIPC
   vectors[14] = {32'h12345a37, 32'h11112222, 32'h33334444, 32'h12345000, 1'b1};
   vectors[15] = {32'hfffffab7, 32'h00000000, 32'hffffffff, 32'hfffff000, 1'b1};
   vectors[16] = {32'h00001b17, 32'h87654321, 32'h00000000, 32'h80001040, 1'b1};
   vectors[17] = {32'hfffffb97, 32'h00000000, 32'h87654321, 32'h7ffff044, 1'b1};
   // rd of x0, then unsupported encodings
   vectors[18] = {32'h00208033, 32'h00000001, 32'h00000002, 32'h00000000, 1'b0};
   vectors[19] = {32'h12345037, 32'hffffffff, 32'hffffffff, 32'h00000000, 1'b0};
   vectors[20] = {32'h0000a283, 32'h00000100, 32'h00000000, 32'h00000000, 1'b0};
   vectors[21] = {32'h00209333, 32'h00000003, 32'h00000004, 32'h00000000, 1'b0};
   vectors[22] = {32'h001080b3, 32'h40000000, 32'h40000000, 32'h80000000, 1'b1};
   vectors[23] = {32'h41df4fb3, 32'h0000ffff, 32'hffff0000, 32'h00000000, 1'b0};
endtask

`endif

/* dv/serv_tb.sv */
`timescale 1ns/1ps

module serv_tb import serv_pkg::*; ();

   localparam word_t       RESET_PC   = 32'h8000_0000;
   localparam int          CLK_PERIOD = 40;
   localparam int          DRIVE_DLY  = 2;
   localparam int          MAX_STALL  = 7;
   localparam logic [31:0] LFSR_SEED  = 32'ha3289eef;

   typedef struct packed {
      word_t instr;
      word_t rs1;
      word_t rs2;
      word_t result;
      logic  we;
   } vec_t;

   `include "serv_tb_vectors.svh"

   // Worst case per row is about 50 cycles with both stalls at the maximum
   localparam int TIMEOUT_CYCLES = NUM_ROWS * (40 + 2 * MAX_STALL) + 50;

   logic        clk = 1'b0;
   logic        i_reset;
   word_t       o_ibus_adr;
   logic        o_ibus_cyc;
   word_t       i_ibus_rdt;
   logic        i_ibus_ack;
   logic        o_rf_rreq;
   reg_addr_t   o_rreg0;
   reg_addr_t   o_rreg1;
   logic        i_rf_ready;
   logic        i_rdata0;
   logic        i_rdata1;
   reg_addr_t   o_wreg0;
   logic        o_wen0;
   logic        o_wdata0;

   logic [31:0] lfsr_state;
   int unsigned cycle_count = 0;
   word_t       expected_pc;

   serv_top #(
      .RESET_PC (RESET_PC)
   ) serv_top_i (
      .clk        (clk),
      .i_reset    (i_reset),
      .o_ibus_adr (o_ibus_adr),
      .o_ibus_cyc (o_ibus_cyc),
      .i_ibus_rdt (i_ibus_rdt),
      .i_ibus_ack (i_ibus_ack),
      .o_rf_rreq  (o_rf_rreq),
      .o_rreg0    (o_rreg0),
      .o_rreg1    (o_rreg1),
      .i_rf_ready (i_rf_ready),
      .i_rdata0   (i_rdata0),
      .i_rdata1   (i_rdata1),
      .o_wreg0    (o_wreg0),
      .o_wen0     (o_wen0),
      .o_wdata0   (o_wdata0)
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= TIMEOUT_CYCLES) begin
         $display("Run timed out: no finish within %0d cycles", TIMEOUT_CYCLES);
         $display("Result: FAILED");
         $fatal(1, "timeout");
      end
   end

   // Taps 32, 22, 2, 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   task automatic random_bits(input int n, output int unsigned value);
      int b;
      value = 0;
      for (b = 0; b < n; b++) begin
         lfsr_state = lfsr_next(lfsr_state);
         value = (value << 1) | lfsr_state[0];
      end
   endtask

   task automatic check_value(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
      if (actual !== expected) begin
         $display("[ERROR] %0t ns %s: actual %h, expected %h",
                  $time, name, actual, expected);
         $display("Result: FAILED");
         $fatal(1, "value mismatch");
      end
   endtask

   // Instruction bus model, ack after a random stall
   task automatic serve_fetch(input vec_t row);
      int unsigned stall;
      int n;
      @(negedge clk);
      while (o_ibus_cyc !== 1'b1) begin
         check_value("o_wen0", o_wen0, 1'b0);
         @(negedge clk);
      end
      check_value("o_ibus_adr", o_ibus_adr, expected_pc);
      random_bits(3, stall);
      for (n = 0; n < stall; n++) begin
         @(posedge clk);
         @(negedge clk);
         check_value("o_ibus_cyc", o_ibus_cyc, 1'b1);
         check_value("o_ibus_adr", o_ibus_adr, expected_pc);
         check_value("o_wen0", o_wen0, 1'b0);
      end
      @(posedge clk);
      #DRIVE_DLY;
      i_ibus_ack = 1'b1;
      i_ibus_rdt = row.instr;
      @(posedge clk);
      #DRIVE_DLY;
      i_ibus_ack = 1'b0;
      i_ibus_rdt = '0;
   endtask

   // Register file model, ready after a random stall, then operands LSB first
   task automatic serve_operands(input vec_t row, output word_t result);
      int unsigned stall;
      int n;
      int k;
      @(negedge clk);
      check_value("o_rf_rreq", o_rf_rreq, 1'b1);
      check_value("o_ibus_cyc", o_ibus_cyc, 1'b0);
      check_value("o_rreg0", o_rreg0, row.instr[19:15]);
      check_value("o_rreg1", o_rreg1, row.instr[24:20]);
      check_value("o_wreg0", o_wreg0, row.instr[11:7]);
      random_bits(3, stall);
      for (n = 0; n < stall; n++) begin
         @(posedge clk);
         @(negedge clk);
         check_value("o_rf_rreq", o_rf_rreq, 1'b0);
         check_value("o_wen0", o_wen0, 1'b0);
         check_value("o_ibus_adr", o_ibus_adr, expected_pc);
      end
      @(posedge clk);
      #DRIVE_DLY;
      i_rf_ready = 1'b1;
      @(posedge clk);
      #DRIVE_DLY;
      i_rf_ready = 1'b0;
      for (k = 0; k < XLEN; k++) begin
         i_rdata0 = row.rs1[k];
         i_rdata1 = row.rs2[k];
         @(negedge clk);
         check_value("o_wen0", o_wen0, row.we);
         check_value("o_wreg0", o_wreg0, row.instr[11:7]);
         result[k] = o_wdata0;
         @(posedge clk);
         #DRIVE_DLY;
      end
      i_rdata0 = 1'b0;
      i_rdata1 = 1'b0;
   endtask

   initial begin
      word_t result;
      int r;
      i_reset     = 1'b1;
      i_ibus_ack  = 1'b0;
      i_ibus_rdt  = '0;
      i_rf_ready  = 1'b0;
      i_rdata0    = 1'b0;
      i_rdata1    = 1'b0;
      lfsr_state  = LFSR_SEED;
      expected_pc = RESET_PC;
      load_vectors();

      repeat (3) begin
         @(posedge clk);
         #DRIVE_DLY;
         check_value("o_ibus_cyc", o_ibus_cyc, 1'b0);
         check_value("o_rf_rreq", o_rf_rreq, 1'b0);
         check_value("o_wen0", o_wen0, 1'b0);
      end
      i_reset = 1'b0;

      for (r = 0; r < NUM_ROWS; r++) begin
         serve_fetch(vectors[r]);
         serve_operands(vectors[r], result);
         if (vectors[r].we) begin
            check_value("o_wdata0", result, vectors[r].result);
         end
         expected_pc = expected_pc + 32'd4;
      end

      // One more fetch request must follow the last row
      @(negedge clk);
      check_value("o_ibus_cyc", o_ibus_cyc, 1'b1);
      check_value("o_ibus_adr", o_ibus_adr, expected_pc);
      $display("Result: PASSED");
      $finish;
   end

endmodule

/* serv_top.f */
+incdir+dv
design/serv_pkg.sv
design/serv_counter.sv
design/serv_state.sv
design/serv_decode.sv
design/serv_immdec.sv
design/serv_alu.sv
design/serv_ctrl.sv
design/serv_top.sv
dv/serv_tb.sv

/* Bender.yml */
package:
  name: serv_top

sources:
  - design/serv_pkg.sv
  - design/serv_counter.sv
  - design/serv_state.sv
  - design/serv_decode.sv
  - design/serv_immdec.sv
  - design/serv_alu.sv
  - design/serv_ctrl.sv
  - design/serv_top.sv
  - target: test
    include_dirs:
      - dv
    files:
      - dv/serv_tb.sv
